// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing
TOP       := tb_led_motion
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/centroid_divider.sv ====
`timescale 1ns/100ps

module centroid_divider import motion_pkg::*; (
    input  logic               clk_65mhz,
    input  logic               reset_8frame_delta_values,
    input  logic               req,
    input  logic [SUM_W-1:0]   dividend,
    input  logic [COUNT_W-1:0] divisor,
    output logic               ack,
    output logic [SUM_W-1:0]   quotient
);

    logic                 running;
    logic [DIV_CNT_W-1:0] bit_cnt;
    logic [COUNT_W-1:0]   rem;
    logic [COUNT_W-1:0]   div_q;
    logic [COUNT_W:0]     shifted;
    logic                 fits;

    // restoring step on the next dividend bit
    assign shifted = {rem, quotient[SUM_W-1]};
    assign fits    = shifted >= {1'b0, div_q};

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            running <= 1'b0;
            ack     <= 1'b0;
        end else if (running) begin
            if (bit_cnt == DIV_CNT_W'(SUM_W - 1)) begin
                running <= 1'b0;
                ack     <= 1'b1;
            end
        end else if (ack) begin
            // four-phase release
            if (!req) begin
                ack <= 1'b0;
            end
        end else if (req) begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (running) begin
            bit_cnt  <= bit_cnt + 1'b1;
            rem      <= fits ? COUNT_W'(shifted - {1'b0, div_q}) : shifted[COUNT_W-1:0];
            quotient <= {quotient[SUM_W-2:0], fits};
        end else if (req && !ack) begin
            bit_cnt  <= '0;
            rem      <= '0;
            div_q    <= divisor;
            quotient <= dividend;
        end
    end

endmodule

// ==== hw/frame_sequencer.sv ====
`timescale 1ns/100ps

module frame_sequencer import motion_pkg::*; (
    input  logic                   clk_65mhz,
    input  logic                   reset_8frame_delta_values,
    input  logic                   frame_done,
    input  logic [NUM_PLAYERS-1:0] div_ack,
    output logic                   frame_end,
    output logic                   div_req,
    output logic                   step,
    output logic                   motion_done,
    output logic                   clear_motion,
    output logic                   motion_valid
);

    logic                   frame_done_d;
    logic                   busy;
    logic                   pending;
    logic [FRAME_CNT_W-1:0] frame_cnt;

    assign frame_end = frame_done && !frame_done_d;

    ////////////////////////////////////////
    // division handshake
    ////////////////////////////////////////
    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            frame_done_d <= 1'b0;
            div_req      <= 1'b0;
            busy         <= 1'b0;
            pending      <= 1'b0;
            step         <= 1'b0;
        end else begin
            frame_done_d <= frame_done;
            step         <= 1'b0;
            // frame end during a busy handshake is served later
            if (frame_end && busy) begin
                pending <= 1'b1;
            end
            if (div_req) begin
                if (&div_ack) begin
                    div_req <= 1'b0;
                end
            end else if (busy) begin
                if (~|div_ack) begin
                    busy <= 1'b0;
                    step <= 1'b1;
                end
            end else if (frame_end || pending) begin
                div_req <= 1'b1;
                busy    <= 1'b1;
                pending <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // eight-frame motion window
    ////////////////////////////////////////
    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            frame_cnt    <= '0;
            motion_done  <= 1'b0;
            clear_motion <= 1'b0;
            motion_valid <= 1'b0;
        end else begin
            motion_done  <= step && (frame_cnt == FRAME_CNT_W'(FRAMES_PER_MOTION - 1));
            // judge output and accumulator clear both follow motion_done
            clear_motion <= motion_done;
            motion_valid <= motion_done;
            if (step) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/gesture_judge.sv ====
`timescale 1ns/100ps

module gesture_judge import motion_pkg::*; (
    input  logic                clk_65mhz,
    input  logic                reset_8frame_delta_values,
    input  logic                motion_done,
    input  logic [MOTION_W-1:0] p1_dx,
    input  logic [MOTION_W-1:0] p1_dy,
    input  logic [MOTION_W-1:0] p2_dx,
    input  logic [MOTION_W-1:0] p2_dy,
    output logic                p1_punch,
    output logic                p1_kick,
    output logic                p2_punch,
    output logic                p2_kick
);

    // mostly horizontal
    function automatic logic is_punch(input logic [MOTION_W-1:0] dx,
                                      input logic [MOTION_W-1:0] dy);
        return (dx > MOTION_W'(PUNCH_DX_MIN)) && (dy < MOTION_W'(PUNCH_DY_MAX));
    endfunction

    // mostly vertical
    function automatic logic is_kick(input logic [MOTION_W-1:0] dx,
                                     input logic [MOTION_W-1:0] dy);
        return (dy > MOTION_W'(KICK_DY_MIN)) && (dx < MOTION_W'(KICK_DX_MAX));
    endfunction

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            p1_punch <= 1'b0;
            p1_kick  <= 1'b0;
            p2_punch <= 1'b0;
            p2_kick  <= 1'b0;
        end else if (motion_done) begin
            p1_punch <= is_punch(p1_dx, p1_dy);
            p1_kick  <= is_kick(p1_dx, p1_dy);
            p2_punch <= is_punch(p2_dx, p2_dy);
            p2_kick  <= is_kick(p2_dx, p2_dy);
        end
    end

endmodule

// ==== hw/led_motion_top.sv ====
`timescale 1ns/100ps

module led_motion_top import motion_pkg::*; (
    input  logic                clk_65mhz,
    input  logic                reset_8frame_delta_values,
    input  logic                pixel_valid,
    input  logic [PIXEL_W-1:0]  pixel,
    input  logic [HCOUNT_W-1:0] hcount,
    input  logic [VCOUNT_W-1:0] vcount,
    input  logic                frame_done,
    output logic                p1_punch,
    output logic                p1_kick,
    output logic                p2_punch,
    output logic                p2_kick,
    output logic                motion_valid
);

    logic [NUM_PLAYERS-1:0] hit;
    logic [NUM_PLAYERS-1:0] div_ack;
    logic [X_W-1:0]         x_mirror;
    logic [Y_W-1:0]         y;
    logic                   frame_end, div_req, step, motion_done, clear_motion;
    logic [MOTION_W-1:0]    motion_dx [NUM_PLAYERS];
    logic [MOTION_W-1:0]    motion_dy [NUM_PLAYERS];

    pixel_classifier classifier_i (
        .clk_65mhz(clk_65mhz), .reset_8frame_delta_values(reset_8frame_delta_values),
        .pixel_valid(pixel_valid), .pixel(pixel), .hcount(hcount), .vcount(vcount),
        .hit(hit), .x_mirror(x_mirror), .y(y)
    );

    frame_sequencer sequencer_i (
        .clk_65mhz(clk_65mhz), .reset_8frame_delta_values(reset_8frame_delta_values),
        .frame_done(frame_done), .div_ack(div_ack), .frame_end(frame_end),
        .div_req(div_req), .step(step), .motion_done(motion_done),
        .clear_motion(clear_motion), .motion_valid(motion_valid)
    );

    // one tracker per led
    for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_track
        player_tracker tracker_i (
            .clk_65mhz(clk_65mhz), .reset_8frame_delta_values(reset_8frame_delta_values),
            .hit(hit[i]), .x_mirror(x_mirror), .y(y), .frame_end(frame_end),
            .div_req(div_req), .step(step), .clear_motion(clear_motion),
            .div_ack(div_ack[i]), .motion_dx(motion_dx[i]), .motion_dy(motion_dy[i])
        );
    end

    gesture_judge judge_i (
        .clk_65mhz(clk_65mhz), .reset_8frame_delta_values(reset_8frame_delta_values),
        .motion_done(motion_done),
        .p1_dx(motion_dx[0]), .p1_dy(motion_dy[0]),
        .p2_dx(motion_dx[1]), .p2_dy(motion_dy[1]),
        .p1_punch(p1_punch), .p1_kick(p1_kick), .p2_punch(p2_punch), .p2_kick(p2_kick)
    );

endmodule

// ==== hw/motion_pkg.sv ====
package motion_pkg;

    ////////////////////////////////////////
    // camera window and pixel input
    ////////////////////////////////////////
    localparam int NUM_PLAYERS = 2;
    localparam int FRAME_W     = 320;
    localparam int FRAME_H     = 240;
    localparam int HCOUNT_W    = 11;
    localparam int VCOUNT_W    = 10;
    localparam int X_W         = 9;
    localparam int Y_W         = 8;
    localparam int PIXEL_W     = 12;
    localparam int CHAN_W      = 4;

    // colour thresholds on one RGB444 channel
    localparam int BRIGHT_MIN  = 12;
    localparam int DARK_MAX    = 3;

    ////////////////////////////////////////
    // tracking and gesture decision
    ////////////////////////////////////////
    localparam int COUNT_W           = 16;
    localparam int SUM_W             = 24;
    localparam int MOTION_W          = 13;
    localparam int FRAMES_PER_MOTION = 8;
    localparam int FRAME_CNT_W       = $clog2(FRAMES_PER_MOTION);
    // one quotient bit per cycle
    localparam int DIV_CNT_W         = $clog2(SUM_W + 1);

    localparam int PUNCH_DX_MIN = 'h60;
    localparam int PUNCH_DY_MAX = 'h30;
    localparam int KICK_DY_MIN  = 'h40;
    localparam int KICK_DX_MAX  = 'h30;

endpackage

// ==== hw/pixel_classifier.sv ====
`timescale 1ns/100ps

module pixel_classifier import motion_pkg::*; (
    input  logic                   clk_65mhz,
    input  logic                   reset_8frame_delta_values,
    input  logic                   pixel_valid,
    input  logic [PIXEL_W-1:0]     pixel,
    input  logic [HCOUNT_W-1:0]    hcount,
    input  logic [VCOUNT_W-1:0]    vcount,
    output logic [NUM_PLAYERS-1:0] hit,
    output logic [X_W-1:0]         x_mirror,
    output logic [Y_W-1:0]         y
);

    logic [CHAN_W-1:0]      red;
    logic [CHAN_W-1:0]      green;
    logic [CHAN_W-1:0]      blue;
    logic                   in_window;
    logic [HCOUNT_W-1:0]    x_full;
    logic [NUM_PLAYERS-1:0] hit_next;

    // rgb444 channel split
    assign red   = pixel[3*CHAN_W-1:2*CHAN_W];
    assign green = pixel[2*CHAN_W-1:CHAN_W];
    assign blue  = pixel[CHAN_W-1:0];

    assign in_window = pixel_valid && (hcount < HCOUNT_W'(FRAME_W))
                       && (vcount < VCOUNT_W'(FRAME_H));
    // mirror image, only meaningful inside the window
    assign x_full = HCOUNT_W'(FRAME_W - 1) - hcount;

    always_comb begin
        hit_next = '0;
        if (in_window) begin
            // red led wins over white
            if (red > CHAN_W'(BRIGHT_MIN) && green < CHAN_W'(DARK_MAX)
                    && blue < CHAN_W'(DARK_MAX)) begin
                hit_next[0] = 1'b1;
            end else if (red > CHAN_W'(BRIGHT_MIN) && green > CHAN_W'(BRIGHT_MIN)
                    && blue > CHAN_W'(BRIGHT_MIN)) begin
                hit_next[1] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            hit <= '0;
        end else begin
            hit <= hit_next;
        end
    end

    always_ff @(posedge clk_65mhz) begin
        x_mirror <= x_full[X_W-1:0];
        y        <= vcount[Y_W-1:0];
    end

endmodule

// ==== hw/player_tracker.sv ====
`timescale 1ns/100ps

module player_tracker import motion_pkg::*; (
    input  logic                clk_65mhz,
    input  logic                reset_8frame_delta_values,
    input  logic                hit,
    input  logic [X_W-1:0]      x_mirror,
    input  logic [Y_W-1:0]      y,
    input  logic                frame_end,
    input  logic                div_req,
    input  logic                step,
    input  logic                clear_motion,
    output logic                div_ack,
    output logic [MOTION_W-1:0] motion_dx,
    output logic [MOTION_W-1:0] motion_dy
);

    logic [COUNT_W-1:0] count, count_lat;
    logic [SUM_W-1:0]   sum_x, sum_y, sum_x_lat, sum_y_lat;
    logic [SUM_W-1:0]   quot_x, quot_y;
    logic               ack_x, ack_y, ack_d;
    logic [X_W-1:0]     cur_x, prev_x, dx_mag;
    logic [Y_W-1:0]     cur_y, prev_y, dy_mag;
    logic               dx_sign, dy_sign;
    logic               motion_dx_sign, motion_dy_sign;

    // sign-magnitude add, result is {sign, magnitude}
    function automatic logic [MOTION_W:0] sm_add(input logic [MOTION_W-1:0] acc,
                                                 input logic acc_sign,
                                                 input logic [MOTION_W-1:0] d,
                                                 input logic d_sign);
        if (acc_sign == d_sign) begin
            return {acc_sign, acc + d};
        end else if (acc > d) begin
            return {acc_sign, acc - d};
        end
        // equal magnitudes land here with the new sign
        return {d_sign, d - acc};
    endfunction

    ////////////////////////////////////////
    // per-frame sums
    ////////////////////////////////////////
    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            count <= '0;
            sum_x <= '0;
            sum_y <= '0;
        end else if (frame_end) begin
            count <= hit ? COUNT_W'(1) : '0;
            sum_x <= hit ? SUM_W'(x_mirror) : '0;
            sum_y <= hit ? SUM_W'(y) : '0;
        end else if (hit) begin
            count <= count + 1'b1;
            sum_x <= sum_x + SUM_W'(x_mirror);
            sum_y <= sum_y + SUM_W'(y);
        end
    end

    always_ff @(posedge clk_65mhz) begin
        if (frame_end) begin
            count_lat <= count;
            sum_x_lat <= sum_x;
            sum_y_lat <= sum_y;
        end
    end

    centroid_divider div_x_i (
        .clk_65mhz(clk_65mhz), .reset_8frame_delta_values(reset_8frame_delta_values),
        .req(div_req), .dividend(sum_x_lat), .divisor(count_lat),
        .ack(ack_x), .quotient(quot_x)
    );

    centroid_divider div_y_i (
        .clk_65mhz(clk_65mhz), .reset_8frame_delta_values(reset_8frame_delta_values),
        .req(div_req), .dividend(sum_y_lat), .divisor(count_lat),
        .ack(ack_y), .quotient(quot_y)
    );

    assign div_ack = ack_x && ack_y;

    // centroid, held on a frame with no hits
    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values) begin
            ack_d  <= 1'b0;
            cur_x  <= '0;
            prev_x <= '0;
            cur_y  <= '0;
            prev_y <= '0;
        end else begin
            ack_d <= div_ack;
            if (div_ack && !ack_d && count_lat != '0) begin
                prev_x <= cur_x;
                cur_x  <= quot_x[X_W-1:0];
                prev_y <= cur_y;
                cur_y  <= quot_y[Y_W-1:0];
            end
        end
    end

    ////////////////////////////////////////
    // two-frame delta and eight-frame total
    ////////////////////////////////////////
    assign dx_sign = prev_x > cur_x;
    assign dy_sign = prev_y > cur_y;
    assign dx_mag  = dx_sign ? prev_x - cur_x : cur_x - prev_x;
    assign dy_mag  = dy_sign ? prev_y - cur_y : cur_y - prev_y;

    always_ff @(posedge clk_65mhz) begin
        if (reset_8frame_delta_values || clear_motion) begin
            {motion_dx_sign, motion_dx} <= '0;
            {motion_dy_sign, motion_dy} <= '0;
        end else if (step) begin
            {motion_dx_sign, motion_dx} <= sm_add(motion_dx, motion_dx_sign,
                                                  MOTION_W'(dx_mag), dx_sign);
            {motion_dy_sign, motion_dy} <= sm_add(motion_dy, motion_dy_sign,
                                                  MOTION_W'(dy_mag), dy_sign);
        end
    end

endmodule

// ==== sim.f ====
hw/motion_pkg.sv
hw/pixel_classifier.sv
hw/frame_sequencer.sv
hw/centroid_divider.sv
hw/player_tracker.sv
hw/gesture_judge.sv
hw/led_motion_top.sv
sim/tb_led_motion.sv

// ==== sim/tb_led_motion.sv ====
`timescale 1ns/100ps

module tb_led_motion import motion_pkg::*; ();

    localparam int NUM_FRAMES   = 96;
    localparam int NOISE_PIXELS = 12;
    localparam int FLUSH        = 2;
    localparam int HOLD         = 4;
    localparam int GAP          = 3 * (SUM_W + 1) + 5;
    localparam int FRAME_CYCLES = 2 * 4 + NOISE_PIXELS + FLUSH + 1 + HOLD;
    localparam int CYCLE_LIMIT  = (NUM_FRAMES * (FRAME_CYCLES + GAP) + 8) * 2;

    logic                clk_65mhz = 1'b0;
    logic                reset_8frame_delta_values;
    logic                pixel_valid;
    logic [PIXEL_W-1:0]  pixel;
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                frame_done;
    logic                p1_punch, p1_kick, p2_punch, p2_kick, motion_valid;

    logic [15:0]         lfsr = 16'd41;
    int                  cycle_count = 0;
    int                  valid_count = 0;
    int                  frames_done = 0;
    logic [3:0]          expected_q[$];

    // model state per player
    int                  cnt[NUM_PLAYERS], sum_x[NUM_PLAYERS], sum_y[NUM_PLAYERS];
    int                  cur_x[NUM_PLAYERS], prev_x[NUM_PLAYERS];
    int                  cur_y[NUM_PLAYERS], prev_y[NUM_PLAYERS];
    logic [MOTION_W:0]   acc_x[NUM_PLAYERS], acc_y[NUM_PLAYERS];

    led_motion_top dut_i (
        .clk_65mhz(clk_65mhz), .reset_8frame_delta_values(reset_8frame_delta_values),
        .pixel_valid(pixel_valid), .pixel(pixel), .hcount(hcount), .vcount(vcount),
        .frame_done(frame_done), .p1_punch(p1_punch), .p1_kick(p1_kick),
        .p2_punch(p2_punch), .p2_kick(p2_kick), .motion_valid(motion_valid)
    );

    always #4 clk_65mhz = ~clk_65mhz;

    ////////////////////////////////////////
    // random bits and error reporting
    ////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return val;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_gesture(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAILED at %0t: %s is %0b, model expects %0b", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("FAILED at %0t: %s is %0d, model expects %0d", $time, name, got, expected);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic logic [1:0] classify(input logic pv, input logic [PIXEL_W-1:0] pix,
                                            input int h, input int v);
        int r, g, b;
        r = int'(pix[11:8]);
        g = int'(pix[7:4]);
        b = int'(pix[3:0]);
        if (!pv || h >= FRAME_W || v >= FRAME_H) return 2'b00;
        if (r > BRIGHT_MIN && g < DARK_MAX && b < DARK_MAX) return 2'b01;
        if (r > BRIGHT_MIN && g > BRIGHT_MIN && b > BRIGHT_MIN) return 2'b10;
        return 2'b00;
    endfunction

    // {sign, magnitude} total plus a signed two-frame delta
    function automatic logic [MOTION_W:0] add_delta(input logic [MOTION_W:0] acc, input int delta);
        int   mag, dmag;
        logic s, ds;
        s    = acc[MOTION_W];
        mag  = int'(acc[MOTION_W-1:0]);
        ds   = delta < 0;
        dmag = ds ? -delta : delta;
        if (s == ds) begin
            mag = mag + dmag;
        end else if (mag > dmag) begin
            mag = mag - dmag;
        end else begin
            mag = dmag - mag;
            s   = ds;
        end
        return {s, MOTION_W'(mag)};
    endfunction

    function automatic logic [1:0] judge(input logic [MOTION_W:0] ax, input logic [MOTION_W:0] ay);
        int dx, dy;
        dx = int'(ax[MOTION_W-1:0]);
        dy = int'(ay[MOTION_W-1:0]);
        return {dx > PUNCH_DX_MIN && dy < PUNCH_DY_MAX, dy > KICK_DY_MIN && dx < KICK_DX_MAX};
    endfunction

    task automatic update_model();
        logic [3:0] decision;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            // zero hits hold the centroid
            if (cnt[p] != 0) begin
                prev_x[p] = cur_x[p];
                cur_x[p]  = sum_x[p] / cnt[p];
                prev_y[p] = cur_y[p];
                cur_y[p]  = sum_y[p] / cnt[p];
            end
            acc_x[p] = add_delta(acc_x[p], cur_x[p] - prev_x[p]);
            acc_y[p] = add_delta(acc_y[p], cur_y[p] - prev_y[p]);
            cnt[p]   = 0;
            sum_x[p] = 0;
            sum_y[p] = 0;
        end
        frames_done = frames_done + 1;
        if (frames_done % FRAMES_PER_MOTION == 0) begin
            decision = {judge(acc_x[0], acc_y[0]), judge(acc_x[1], acc_y[1])};
            expected_q.push_back(decision);
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                acc_x[p] = '0;
                acc_y[p] = '0;
            end
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic drive_pixel(input logic pv, input logic [PIXEL_W-1:0] pix, input int h,
                               input int v);
        logic [1:0] cls;
        @(posedge clk_65mhz);
        pixel_valid <= pv;
        pixel       <= pix;
        hcount      <= HCOUNT_W'(h);
        vcount      <= VCOUNT_W'(v);
        cls = classify(pv, pix, h, v);
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            if (cls[p]) begin
                cnt[p]   = cnt[p] + 1;
                sum_x[p] = sum_x[p] + FRAME_W - 1 - h;
                sum_y[p] = sum_y[p] + v;
            end
        end
    endtask

    // mode 0 back and forth, 1 red sweep, 2 white lift, 3 random
    task automatic run_frame(input int mode, input int k);
        int                 h[NUM_PLAYERS], v[NUM_PLAYERS];
        logic [PIXEL_W-1:0] col[NUM_PLAYERS];
        logic               present[NUM_PLAYERS];
        col[0]     = 12'hF11;
        col[1]     = 12'hEEE;
        present[0] = 1'b1;
        present[1] = 1'b1;
        h[0] = (k % 2 == 1) ? 210 : 150;
        v[0] = 100;
        h[1] = 200;
        v[1] = (mode == 0 && k % 2 == 0) ? 60 : 120;
        if (mode == 1) h[0] = 230 - 28 * k;
        if (mode == 2) begin
            h[0] = 210;
            v[1] = 20 + 28 * k;
        end
        if (mode == 3) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                present[p] = take_bits(2) != 0;
                h[p]       = take_bits(9);
                v[p]       = take_bits(8);
                if (take_bits(2) == 0) col[p] = PIXEL_W'(take_bits(12));
            end
        end
        // 2x2 blob per led
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            if (present[p]) begin
                for (int d = 0; d < 4; d++) begin
                    drive_pixel(1'b1, col[p], h[p] + d % 2, v[p] + d / 2);
                end
            end
        end
        // dim noise only outside the random mode
        for (int n = 0; n < NOISE_PIXELS; n++) begin
            drive_pixel(take_bits(3) != 0,
                        PIXEL_W'(take_bits(12)) & ((mode == 3) ? 12'hFFF : 12'h777),
                        take_bits(9), take_bits(8));
        end
        repeat (FLUSH) drive_pixel(1'b0, '0, 0, 0);
        @(posedge clk_65mhz);
        frame_done <= 1'b1;
        update_model();
        repeat (HOLD - 1) @(posedge clk_65mhz);
        @(posedge clk_65mhz);
        frame_done <= 1'b0;
        repeat (GAP) @(posedge clk_65mhz);
    endtask

    ////////////////////////////////////////
    // decision monitor and timeout
    ////////////////////////////////////////
    always @(posedge clk_65mhz) begin
        logic [3:0] exp;
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
        if (!reset_8frame_delta_values && motion_valid) begin
            valid_count = valid_count + 1;
            if (expected_q.size() == 0) begin
                $display("motion_valid pulsed while no gesture decision was due");
                abort_run();
            end else begin
                exp = expected_q.pop_front();
                check_gesture("p1_punch", p1_punch, exp[3]);
                check_gesture("p1_kick", p1_kick, exp[2]);
                check_gesture("p2_punch", p2_punch, exp[1]);
                check_gesture("p2_kick", p2_kick, exp[0]);
                // sweep and lift windows have a fixed outcome
                if (valid_count == 2) begin
                    check_gesture("p1_punch after red sweep", p1_punch, 1'b1);
                    check_gesture("p1_kick after red sweep", p1_kick, 1'b0);
                end
                if (valid_count == 3) begin
                    check_gesture("p2_kick after white lift", p2_kick, 1'b1);
                end
            end
        end
    end

    initial begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            cnt[p]    = 0;
            sum_x[p]  = 0;
            sum_y[p]  = 0;
            cur_x[p]  = 0;
            prev_x[p] = 0;
            cur_y[p]  = 0;
            prev_y[p] = 0;
            acc_x[p]  = '0;
            acc_y[p]  = '0;
        end
        reset_8frame_delta_values <= 1'b1;
        pixel_valid <= 1'b0;
        pixel       <= '0;
        hcount      <= '0;
        vcount      <= '0;
        frame_done  <= 1'b0;
        repeat (2) @(posedge clk_65mhz);
        reset_8frame_delta_values <= 1'b0;
        @(posedge clk_65mhz);
        check_gesture("p1_punch", p1_punch, 1'b0);
        check_gesture("p1_kick", p1_kick, 1'b0);
        check_gesture("p2_punch", p2_punch, 1'b0);
        check_gesture("p2_kick", p2_kick, 1'b0);
        check_gesture("motion_valid", motion_valid, 1'b0);
        // windows 0 and 3 reverse, 1 punch, 2 kick, then random
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame((f / 8 == 0 || f / 8 == 3) ? 0 : (f / 8 < 3) ? f / 8 : 3, f % 8);
        end
        check_count("motion_valid pulses", valid_count, NUM_FRAMES / FRAMES_PER_MOTION);
        $display("Regression passed");
        $finish;
    end

endmodule
